// ==== logic/lru_tracker.sv ====
`timescale 1ns/1ps

module lru_tracker #(
    parameter int NUM_WAYS = 4
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        hit_i,
    input  logic [$clog2(NUM_WAYS)-1:0] hit_way_i,
    input  logic                        refill_i,
    output logic [$clog2(NUM_WAYS)-1:0] victim_o
);

    localparam int WAY_BITS = $clog2(NUM_WAYS);
    localparam int PAIRS    = NUM_WAYS * (NUM_WAYS - 1) / 2;

    // Bit for pair (lo, hi) is set when way lo is older than way hi
    logic [PAIRS-1:0] order_q;
    logic [PAIRS-1:0] order_hit;
    logic [PAIRS-1:0] order_d;

    // Flat index of pair (lo, hi), lo < hi
    function automatic int pair_idx(input int lo, input int hi);
        return lo * (2 * NUM_WAYS - lo - 1) / 2 + (hi - lo - 1);
    endfunction

    function automatic logic [PAIRS-1:0] make_newest(
        input logic [PAIRS-1:0]    order,
        input logic [WAY_BITS-1:0] way
    );
        logic [PAIRS-1:0] res;
        res = order;
        for (int lo = 0; lo < NUM_WAYS; lo++) begin
            for (int hi = lo + 1; hi < NUM_WAYS; hi++) begin
                if (hi == int'(way)) begin
                    res[pair_idx(lo, hi)] = 1'b1;
                end else if (lo == int'(way)) begin
                    res[pair_idx(lo, hi)] = 1'b0;
                end
            end
        end
        return res;
    endfunction

    // Way that is older than every other way
    function automatic logic [WAY_BITS-1:0] oldest(input logic [PAIRS-1:0] order);
        logic [WAY_BITS-1:0] res;
        logic                is_oldest;
        res = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            is_oldest = 1'b1;
            for (int o = 0; o < NUM_WAYS; o++) begin
                if (o < w) begin
                    is_oldest = is_oldest & ~order[pair_idx(o, w)];
                end else if (o > w) begin
                    is_oldest = is_oldest & order[pair_idx(w, o)];
                end
            end
            if (is_oldest) begin
                res = WAY_BITS'(w);
            end
        end
        return res;
    endfunction

    // Hit first, then the refill takes whatever is oldest after it
    always_comb begin
        order_hit = order_q;
        if (hit_i) begin
            order_hit = make_newest(order_q, hit_way_i);
        end
        order_d = order_hit;
        if (refill_i) begin
            order_d = make_newest(order_hit, oldest(order_hit));
        end
    end

    // All ones: way 0 oldest up to the last way newest
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            order_q <= '1;
        end else begin
            order_q <= order_d;
        end
    end

    assign victim_o = oldest(order_q);

endmodule : lru_tracker

// ==== logic/miss_latch.sv ====
`timescale 1ns/1ps

module miss_latch (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          miss_i,
    input  logic [mmu_pkg::ADDR_BITS-1:0] addr_i,
    input  logic                          retire_i,
    output logic                          pending_o,
    output logic [mmu_pkg::ADDR_BITS-1:0] line_addr_o,
    output logic [mmu_pkg::ADDR_BITS-1:0] full_addr_o
);

    import mmu_pkg::*;

    logic                 pending_q;
    logic [ADDR_BITS-1:0] addr_q;

    // A miss only lands while nothing is outstanding
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
        end else if (!pending_q && miss_i) begin
            pending_q <= 1'b1;
        end else if (retire_i) begin
            pending_q <= 1'b0;
        end
    end

    // Address stays valid through the refill pulse
    always_ff @(posedge clk_i) begin
        if (!pending_q && miss_i) begin
            addr_q <= addr_i;
        end
    end

    assign pending_o   = pending_q;
    assign full_addr_o = addr_q;

    // Memory fetches whole lines
    assign line_addr_o = {addr_q[ADDR_BITS-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

endmodule : miss_latch

// ==== logic/mmu.sv ====
`timescale 1ns/1ps

module mmu #(
    parameter int DC_WAYS = 4,
    parameter int IC_WAYS = 2
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    // Data cache
    input  logic                          dc_miss_i,
    input  logic [mmu_pkg::ADDR_BITS-1:0] dc_addr_i,
    input  logic                          dc_hit_i,
    input  logic [$clog2(DC_WAYS)-1:0]    dc_hit_way_i,
    input  logic                          dc_store_i,
    input  logic [mmu_pkg::ADDR_BITS-1:0] dc_store_addr_i,
    input  logic [mmu_pkg::WORD_BITS-1:0] dc_store_data_i,
    input  mmu_pkg::memop_size_e          dc_store_size_i,
    output logic                          dc_refill_rdy_o,
    output logic [mmu_pkg::LINE_BITS-1:0] dc_refill_data_o,
    output logic [mmu_pkg::ADDR_BITS-1:0] dc_refill_addr_o,
    output logic [$clog2(DC_WAYS)-1:0]    dc_refill_way_o,
    // Instruction cache
    input  logic                          ic_miss_i,
    input  logic [mmu_pkg::ADDR_BITS-1:0] ic_addr_i,
    input  logic                          ic_hit_i,
    input  logic [$clog2(IC_WAYS)-1:0]    ic_hit_way_i,
    output logic                          ic_refill_rdy_o,
    output logic [mmu_pkg::LINE_BITS-1:0] ic_refill_data_o,
    output logic [mmu_pkg::ADDR_BITS-1:0] ic_refill_addr_o,
    output logic [$clog2(IC_WAYS)-1:0]    ic_refill_way_o,
    // Main memory
    input  logic                          mm_data_rdy_i,
    input  logic [mmu_pkg::LINE_BITS-1:0] mm_data_i,
    output logic                          mm_rd_req_o,
    output logic [mmu_pkg::ADDR_BITS-1:0] mm_rd_addr_o,
    output logic                          mm_wr_req_o,
    output logic [mmu_pkg::ADDR_BITS-1:0] mm_wr_addr_o,
    output logic [mmu_pkg::WORD_BITS-1:0] mm_wr_data_o,
    output mmu_pkg::memop_size_e          mm_wr_size_o
);

    import mmu_pkg::*;

    localparam int DC_WAY_BITS = $clog2(DC_WAYS);
    localparam int IC_WAY_BITS = $clog2(IC_WAYS);

    logic                   dc_pending;
    logic                   ic_pending;
    logic [ADDR_BITS-1:0]   dc_line_addr;
    logic [ADDR_BITS-1:0]   ic_line_addr;
    logic                   dc_retire;
    logic                   ic_retire;
    logic [DC_WAY_BITS-1:0] dc_victim;
    logic [IC_WAY_BITS-1:0] ic_victim;
    logic [LINE_BITS-1:0]   refill_data;

    miss_latch i_dc_latch (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .miss_i      (dc_miss_i),
        .addr_i      (dc_addr_i),
        .retire_i    (dc_retire),
        .pending_o   (dc_pending),
        .line_addr_o (dc_line_addr),
        .full_addr_o (dc_refill_addr_o)
    );

    miss_latch i_ic_latch (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .miss_i      (ic_miss_i),
        .addr_i      (ic_addr_i),
        .retire_i    (ic_retire),
        .pending_o   (ic_pending),
        .line_addr_o (ic_line_addr),
        .full_addr_o (ic_refill_addr_o)
    );

    lru_tracker #(.NUM_WAYS(DC_WAYS)) i_dc_lru (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .hit_i     (dc_hit_i),
        .hit_way_i (dc_hit_way_i),
        .refill_i  (dc_retire),
        .victim_o  (dc_victim)
    );

    lru_tracker #(.NUM_WAYS(IC_WAYS)) i_ic_lru (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .hit_i     (ic_hit_i),
        .hit_way_i (ic_hit_way_i),
        .refill_i  (ic_retire),
        .victim_o  (ic_victim)
    );

    refill_arbiter i_arbiter (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .dc_pending_i    (dc_pending),
        .ic_pending_i    (ic_pending),
        .dc_line_addr_i  (dc_line_addr),
        .ic_line_addr_i  (ic_line_addr),
        .mm_data_rdy_i   (mm_data_rdy_i),
        .mm_data_i       (mm_data_i),
        .mm_rd_req_o     (mm_rd_req_o),
        .mm_rd_addr_o    (mm_rd_addr_o),
        .dc_retire_o     (dc_retire),
        .ic_retire_o     (ic_retire),
        .dc_refill_rdy_o (dc_refill_rdy_o),
        .ic_refill_rdy_o (ic_refill_rdy_o),
        .refill_data_o   (refill_data)
    );

    // One line register feeds both caches
    assign dc_refill_data_o = refill_data;
    assign ic_refill_data_o = refill_data;

    // Tracker moves on at retire, so keep the way being replaced
    always_ff @(posedge clk_i) begin
        if (dc_retire) begin
            dc_refill_way_o <= dc_victim;
        end
        if (ic_retire) begin
            ic_refill_way_o <= ic_victim;
        end
    end

    // Store bypass, one stage
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mm_wr_req_o <= 1'b0;
        end else begin
            mm_wr_req_o <= dc_store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dc_store_i) begin
            mm_wr_addr_o <= dc_store_addr_i;
            mm_wr_data_o <= dc_store_data_i;
            mm_wr_size_o <= dc_store_size_i;
        end
    end

endmodule : mmu

// ==== logic/mmu_pkg.sv ====
package mmu_pkg;

    // Bus and line geometry
    localparam int ADDR_BITS        = 32;
    localparam int WORD_BITS        = 32;
    localparam int LINE_BITS        = 128;
    localparam int LINE_OFFSET_BITS = 4;

    // Store access size on the write port
    typedef enum logic [1:0] {
        MEMOP_BYTE = 2'b00,
        MEMOP_HALF = 2'b01,
        MEMOP_WORD = 2'b10
    } memop_size_e;

    // Refill arbiter states, one REQ/WAIT pair per cache
    typedef enum logic [2:0] {
        ARB_IDLE    = 3'd0,
        ARB_DC_REQ  = 3'd1,
        ARB_DC_WAIT = 3'd2,
        ARB_IC_REQ  = 3'd3,
        ARB_IC_WAIT = 3'd4
    } arb_state_e;

endpackage : mmu_pkg

// ==== logic/refill_arbiter.sv ====
`timescale 1ns/1ps

module refill_arbiter (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          dc_pending_i,
    input  logic                          ic_pending_i,
    input  logic [mmu_pkg::ADDR_BITS-1:0] dc_line_addr_i,
    input  logic [mmu_pkg::ADDR_BITS-1:0] ic_line_addr_i,
    input  logic                          mm_data_rdy_i,
    input  logic [mmu_pkg::LINE_BITS-1:0] mm_data_i,
    output logic                          mm_rd_req_o,
    output logic [mmu_pkg::ADDR_BITS-1:0] mm_rd_addr_o,
    output logic                          dc_retire_o,
    output logic                          ic_retire_o,
    output logic                          dc_refill_rdy_o,
    output logic                          ic_refill_rdy_o,
    output logic [mmu_pkg::LINE_BITS-1:0] refill_data_o
);

    import mmu_pkg::*;

    arb_state_e           state_q;
    arb_state_e           state_d;
    logic                 dc_done;
    logic                 ic_done;
    logic [LINE_BITS-1:0] line_q;

    // Last cycle of a read for each cache
    assign dc_done = (state_q == ARB_DC_WAIT) && mm_data_rdy_i;
    assign ic_done = (state_q == ARB_IC_WAIT) && mm_data_rdy_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            ARB_IDLE: begin
                // Data side has priority
                if (dc_pending_i) begin
                    state_d = ARB_DC_REQ;
                end else if (ic_pending_i) begin
                    state_d = ARB_IC_REQ;
                end
            end
            ARB_DC_REQ: begin
                state_d = ARB_DC_WAIT;
            end
            ARB_DC_WAIT: begin
                if (mm_data_rdy_i) begin
                    state_d = ic_pending_i ? ARB_IC_REQ : ARB_IDLE;
                end
            end
            ARB_IC_REQ: begin
                state_d = ARB_IC_WAIT;
            end
            ARB_IC_WAIT: begin
                if (mm_data_rdy_i) begin
                    state_d = dc_pending_i ? ARB_DC_REQ : ARB_IDLE;
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request lasts exactly the one REQ cycle
    assign mm_rd_req_o  = (state_q == ARB_DC_REQ) || (state_q == ARB_IC_REQ);
    assign mm_rd_addr_o = (state_q == ARB_IC_REQ) ? ic_line_addr_i : dc_line_addr_i;

    // Retire also doubles as the tracker refill strobe
    assign dc_retire_o = dc_done;
    assign ic_retire_o = ic_done;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dc_refill_rdy_o <= 1'b0;
            ic_refill_rdy_o <= 1'b0;
        end else begin
            dc_refill_rdy_o <= dc_done;
            ic_refill_rdy_o <= ic_done;
        end
    end

    // Returned line, held until the next read completes
    always_ff @(posedge clk_i) begin
        if (dc_done || ic_done) begin
            line_q <= mm_data_i;
        end
    end

    assign refill_data_o = line_q;

endmodule : refill_arbiter

// ==== mmu.f ====
logic/mmu_pkg.sv
logic/miss_latch.sv
logic/lru_tracker.sv
logic/refill_arbiter.sv
logic/mmu.sv
tests/clk_gen.sv
tests/mmu_asserts.sv
tests/mmu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module mmu_tb -f mmu.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vmmu_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Released on a falling edge like every other input
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule : clk_gen

// ==== tests/mmu_asserts.sv ====
`timescale 1ns/1ps

module mmu_asserts (
    input logic                clk_i,
    input logic                reset_i,
    input mmu_pkg::arb_state_e state_i,
    input logic                mm_rd_req_i,
    input logic                mm_data_rdy_i,
    input logic                dc_refill_rdy_i,
    input logic                ic_refill_rdy_i,
    input logic                dc_refill_i,
    input logic                ic_refill_i,
    input logic                dc_hit_i,
    input logic                ic_hit_i
);

    import mmu_pkg::*;

    logic answered_q;
    logic ic_side_q;

    // Memory answer seen since the last request or ready pulse
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            answered_q <= 1'b0;
        end else if (mm_rd_req_i || dc_refill_rdy_i || ic_refill_rdy_i) begin
            answered_q <= 1'b0;
        end else if (mm_data_rdy_i) begin
            answered_q <= 1'b1;
        end
    end

    // Cache that the outstanding read was issued for
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ic_side_q <= 1'b0;
        end else if (mm_rd_req_i) begin
            ic_side_q <= (state_i == ARB_IC_REQ);
        end
    end

    a_req_single: assert property (@(posedge clk_i) disable iff (reset_i)
        mm_rd_req_i |=> !mm_rd_req_i)
        else $error("read request held for two cycles");

    a_one_ready: assert property (@(posedge clk_i) disable iff (reset_i)
        !(dc_refill_rdy_i && ic_refill_rdy_i))
        else $error("both refill ready pulses high together");

    a_ready_after_data: assert property (@(posedge clk_i) disable iff (reset_i)
        (dc_refill_rdy_i || ic_refill_rdy_i) |-> answered_q)
        else $error("refill ready without a memory answer");

    // Ready goes to the cache whose read was requested
    a_ready_side: assert property (@(posedge clk_i) disable iff (reset_i)
        !((dc_refill_rdy_i && ic_side_q) || (ic_refill_rdy_i && !ic_side_q)))
        else $error("refill ready pulsed for the wrong cache");

    a_no_hit_refill: assert property (@(posedge clk_i) disable iff (reset_i)
        !(dc_hit_i && dc_refill_i) && !(ic_hit_i && ic_refill_i))
        else $error("tracker saw a hit and a refill in one cycle");

endmodule : mmu_asserts

bind refill_arbiter mmu_asserts i_asserts (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .state_i         (state_q),
    .mm_rd_req_i     (mm_rd_req_o),
    .mm_data_rdy_i   (mm_data_rdy_i),
    .dc_refill_rdy_i (dc_refill_rdy_o),
    .ic_refill_rdy_i (ic_refill_rdy_o),
    .dc_refill_i     (dc_retire_o),
    .ic_refill_i     (ic_retire_o),
    .dc_hit_i        (mmu.dc_hit_i),
    .ic_hit_i        (mmu.ic_hit_i)
);

// ==== tests/mmu_tb.sv ====
`timescale 1ns/1ps

module mmu_tb;

    import mmu_pkg::*;

    localparam int DC_WAYS     = 4;
    localparam int IC_WAYS     = 2;
    localparam int DC_WAY_BITS = $clog2(DC_WAYS);
    localparam int IC_WAY_BITS = $clog2(IC_WAYS);
    localparam int MAX_TESTS   = 64;

    // Opcodes of the test file
    localparam int OP_HIT   = 0;
    localparam int OP_MISS  = 1;
    localparam int OP_BOTH  = 2;
    localparam int OP_STORE = 3;

    logic                   clk;
    logic                   reset;
    logic                   dc_miss_i;
    logic [ADDR_BITS-1:0]   dc_addr_i;
    logic                   dc_hit_i;
    logic [DC_WAY_BITS-1:0] dc_hit_way_i;
    logic                   dc_store_i;
    logic [ADDR_BITS-1:0]   dc_store_addr_i;
    logic [WORD_BITS-1:0]   dc_store_data_i;
    memop_size_e            dc_store_size_i;
    logic                   dc_refill_rdy_o;
    logic [LINE_BITS-1:0]   dc_refill_data_o;
    logic [ADDR_BITS-1:0]   dc_refill_addr_o;
    logic [DC_WAY_BITS-1:0] dc_refill_way_o;
    logic                   ic_miss_i;
    logic [ADDR_BITS-1:0]   ic_addr_i;
    logic                   ic_hit_i;
    logic [IC_WAY_BITS-1:0] ic_hit_way_i;
    logic                   ic_refill_rdy_o;
    logic [LINE_BITS-1:0]   ic_refill_data_o;
    logic [ADDR_BITS-1:0]   ic_refill_addr_o;
    logic [IC_WAY_BITS-1:0] ic_refill_way_o;
    logic                   mm_data_rdy_i;
    logic [LINE_BITS-1:0]   mm_data_i;
    logic                   mm_rd_req_o;
    logic [ADDR_BITS-1:0]   mm_rd_addr_o;
    logic                   mm_wr_req_o;
    logic [ADDR_BITS-1:0]   mm_wr_addr_o;
    logic [WORD_BITS-1:0]   mm_wr_data_o;
    memop_size_e            mm_wr_size_o;

    int                     ntests;
    int                     max_lat;
    int                     op    [MAX_TESTS];
    int                     cache [MAX_TESTS];
    logic [ADDR_BITS-1:0]   addr  [MAX_TESTS];
    logic [LINE_BITS-1:0]   data  [MAX_TESTS];
    int                     lat   [MAX_TESTS];
    int                     way   [MAX_TESTS];
    logic [ADDR_BITS-1:0]   addr2 [MAX_TESTS];
    logic [LINE_BITS-1:0]   data2 [MAX_TESTS];
    int                     way2  [MAX_TESTS];
    // Age order per cache, oldest first
    int                     age   [2][DC_WAYS];
    int                     cycles;
    int                     limit;

    clk_gen i_clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    mmu i_dut (
        .clk_i   (clk),
        .reset_i (reset),
        .*
    );

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_line(input string name, input logic [LINE_BITS-1:0] got,
                              input logic [LINE_BITS-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_BITS-1:0] got,
                              input logic [ADDR_BITS-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_BITS-1:0] got,
                              input logic [WORD_BITS-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_way(input string name, input logic [DC_WAY_BITS-1:0] got,
                             input logic [DC_WAY_BITS-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_size(input string name, input memop_size_e got,
                              input memop_size_e exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic void mark_newest(input int c, input int w);
        int n;
        int pos;
        n = (c == 0) ? DC_WAYS : IC_WAYS;
        pos = 0;
        for (int i = 0; i < n; i++) begin
            if (age[c][i] == w) begin
                pos = i;
            end
        end
        for (int i = pos; i < n - 1; i++) begin
            age[c][i] = age[c][i + 1];
        end
        age[c][n - 1] = w;
    endfunction

    // The file's expected victim must match the model before it is used
    task automatic take_victim(input int c, input int w);
        if (age[c][0] != w) begin
            $display("test file expects victim %0d, the age model gives way %0d", w, age[c][0]);
            stop_run();
        end
        mark_newest(c, w);
    endtask

    function automatic logic [ADDR_BITS-1:0] line_of(input logic [ADDR_BITS-1:0] a);
        logic [ADDR_BITS-1:0] res;
        res = a;
        res[LINE_OFFSET_BITS-1:0] = '0;
        return res;
    endfunction

    task automatic read_tests();
        int    fd;
        int    cnt;
        string text;
        fd = $fopen("tests/mmu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/mmu_tests.txt");
            stop_run();
        end
        ntests = 0;
        max_lat = 0;
        while (!$feof(fd) && ntests < MAX_TESTS) begin
            text = "";
            cnt = $fgets(text, fd);
            if (text.len() > 1 && text[0] != "#") begin
                cnt = $sscanf(text, "%d %d %h %h %d %d %h %h %d", op[ntests], cache[ntests],
                              addr[ntests], data[ntests], lat[ntests], way[ntests],
                              addr2[ntests], data2[ntests], way2[ntests]);
                if (cnt != 9) begin
                    $display("malformed line in test file: %s", text);
                    stop_run();
                end
                if (lat[ntests] > max_lat) begin
                    max_lat = lat[ntests];
                end
                ntests++;
            end
        end
        $fclose(fd);
    endtask

    // Memory model: waits for the request, answers after the latency
    task automatic answer_read(input logic [ADDR_BITS-1:0] a, input logic [LINE_BITS-1:0] line,
                               input int k);
        while (!mm_rd_req_o) begin
            @(negedge clk);
        end
        check_addr("mm_rd_addr_o", mm_rd_addr_o, line_of(a));
        for (int i = 0; i < k; i++) begin
            @(negedge clk);
            if (mm_rd_req_o || mm_wr_req_o || dc_refill_rdy_o || ic_refill_rdy_o) begin
                $display("memory request or refill seen while memory was still busy");
                stop_run();
            end
        end
        mm_data_rdy_i = 1'b1;
        mm_data_i = line;
        @(negedge clk);
        mm_data_rdy_i = 1'b0;
        mm_data_i = '0;
    endtask

    // Ready is due in the cycle right after the memory answer
    task automatic expect_refill(input int c, input logic [ADDR_BITS-1:0] a,
                                 input logic [LINE_BITS-1:0] line, input int w);
        if (!(dc_refill_rdy_o || ic_refill_rdy_o)) begin
            $display("no refill ready pulse one cycle after the memory answer");
            stop_run();
        end
        if (c == 0) begin
            if (!dc_refill_rdy_o) begin
                $display("instruction refill came back where a data refill was due");
                stop_run();
            end
            check_line("dc_refill_data_o", dc_refill_data_o, line);
            check_addr("dc_refill_addr_o", dc_refill_addr_o, a);
            check_way("dc_refill_way_o", dc_refill_way_o, DC_WAY_BITS'(w));
        end else begin
            if (!ic_refill_rdy_o) begin
                $display("data refill came back where an instruction refill was due");
                stop_run();
            end
            check_line("ic_refill_data_o", ic_refill_data_o, line);
            check_addr("ic_refill_addr_o", ic_refill_addr_o, a);
            check_way("ic_refill_way_o", DC_WAY_BITS'(ic_refill_way_o), DC_WAY_BITS'(w));
        end
    endtask

    task automatic run_test(input int t);
        case (op[t])
            OP_HIT: begin
                if (cache[t] == 0) begin
                    dc_hit_i = 1'b1;
                    dc_hit_way_i = DC_WAY_BITS'(way[t]);
                end else begin
                    ic_hit_i = 1'b1;
                    ic_hit_way_i = IC_WAY_BITS'(way[t]);
                end
                @(negedge clk);
                dc_hit_i = 1'b0;
                ic_hit_i = 1'b0;
                mark_newest(cache[t], way[t]);
            end
            OP_MISS: begin
                take_victim(cache[t], way[t]);
                dc_miss_i = (cache[t] == 0);
                ic_miss_i = (cache[t] != 0);
                dc_addr_i = addr[t];
                ic_addr_i = addr[t];
                @(negedge clk);
                dc_miss_i = 1'b0;
                ic_miss_i = 1'b0;
                answer_read(addr[t], data[t], lat[t]);
                expect_refill(cache[t], addr[t], data[t], way[t]);
            end
            OP_BOTH: begin
                take_victim(0, way[t]);
                take_victim(1, way2[t]);
                dc_miss_i = 1'b1;
                dc_addr_i = addr[t];
                ic_miss_i = 1'b1;
                ic_addr_i = addr2[t];
                @(negedge clk);
                dc_miss_i = 1'b0;
                ic_miss_i = 1'b0;
                answer_read(addr[t], data[t], lat[t]);
                expect_refill(0, addr[t], data[t], way[t]);
                answer_read(addr2[t], data2[t], lat[t]);
                expect_refill(1, addr2[t], data2[t], way2[t]);
            end
            OP_STORE: begin
                take_victim(0, way[t]);
                dc_miss_i = 1'b1;
                dc_addr_i = addr[t];
                @(negedge clk);
                dc_miss_i = 1'b0;
                dc_store_i = 1'b1;
                dc_store_addr_i = addr2[t];
                dc_store_data_i = data2[t][WORD_BITS-1:0];
                dc_store_size_i = memop_size_e'(way2[t][1:0]);
                @(negedge clk);
                dc_store_i = 1'b0;
                if (!mm_wr_req_o) begin
                    $display("store did not reach the memory write port one cycle later");
                    stop_run();
                end
                check_addr("mm_wr_addr_o", mm_wr_addr_o, addr2[t]);
                check_word("mm_wr_data_o", mm_wr_data_o, data2[t][WORD_BITS-1:0]);
                check_size("mm_wr_size_o", mm_wr_size_o, memop_size_e'(way2[t][1:0]));
                answer_read(addr[t], data[t], lat[t]);
                expect_refill(0, addr[t], data[t], way[t]);
            end
            default: begin
                $display("unknown opcode %0d in test %0d", op[t], t);
                stop_run();
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("run timed out after %0d cycles", cycles);
            stop_run();
        end
    end

    initial begin
        dc_miss_i = 1'b0;
        dc_addr_i = '0;
        dc_hit_i = 1'b0;
        dc_hit_way_i = '0;
        dc_store_i = 1'b0;
        dc_store_addr_i = '0;
        dc_store_data_i = '0;
        dc_store_size_i = MEMOP_BYTE;
        ic_miss_i = 1'b0;
        ic_addr_i = '0;
        ic_hit_i = 1'b0;
        ic_hit_way_i = '0;
        mm_data_rdy_i = 1'b0;
        mm_data_i = '0;
        cycles = 0;
        limit = 0;
        read_tests();
        limit = ntests * (max_lat + 12);
        for (int i = 0; i < DC_WAYS; i++) begin
            age[0][i] = i;
            age[1][i] = (i < IC_WAYS) ? i : 0;
        end
        wait (!reset);
        @(negedge clk);
        // Quiet until the first miss
        repeat (4) begin
            if (mm_rd_req_o || mm_wr_req_o || dc_refill_rdy_o || ic_refill_rdy_o) begin
                $display("memory or refill activity seen before the first miss");
                stop_run();
            end
            @(negedge clk);
        end
        for (int t = 0; t < ntests; t++) begin
            run_test(t);
        end
        $display("sim passed");
        $finish;
    end

endmodule : mmu_tb

// ==== tests/mmu_tests.txt ====
# op: 0 hit, 1 miss, 2 both-miss, 3 store during data miss; cache: 0 data, 1 instruction
# op cache addr line latency way | addr2 line2 way2 (ic miss, or store addr/data/size)
1 0 00001234 0123456789abcdef0011223344556677 3 0 00000000 0 0
1 0 00002208 fedcba98765432108899aabbccddeeff 2 1 00000000 0 0
1 1 00400010 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 20 0 00000000 0 0
2 0 00003004 11111111222222223333333344444444 4 2 00400124 55555555666666667777777788888888 1
0 0 00000000 0 0 3 00000000 0 0
0 0 00000000 0 0 0 00000000 0 0
1 0 0000400c 0badf00d0badf00dcafebabecafebabe 1 1 00000000 0 0
0 1 00000000 0 0 0 00000000 0 0
1 1 00400238 13579bdf2468ace0fdb97531eca86420 5 1 00000000 0 0
3 0 0000500a 00000001000000020000000300000004 6 2 0000a0b4 deadbeef 2
3 0 00006001 99999999aaaaaaaabbbbbbbbcccccccc 2 3 0000a0b6 0000beef 1
0 0 00000000 0 0 1 00000000 0 0
0 0 00000000 0 0 0 00000000 0 0
1 0 00007ffc 7ffc7ffc7ffc7ffc7ffc7ffc7ffc7ffc 3 2 00000000 0 0
2 0 00008010 8010801080108010c0dec0dec0dec0de 7 3 00400300 00c000c000c000c0deadc0dedeadc0de 0
3 0 00009000 9000900090009000f00df00df00df00d 1 1 0000a0b7 000000a5 0
